// File: include/capture_config.svh
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// number of serial ADCs sharing cs_n
`define CAP_NUM_CHANNELS 4

`define CAP_SAMPLE_BITS 10     // bits per ADC conversion, MSB first

// ring buffer depth, also samples per frame
`define CAP_BUF_DEPTH 16

// samples kept after the trigger sample
// trigger lands at frame position BUF_DEPTH - POST_TRIG - 1
`define CAP_POST_TRIG 8

`define CAP_CHAN_CREDITS 2     // drain slot depth per channel

// words the drain may send before the first tx_credit
`define CAP_TX_CREDITS 4

`define CAP_SAMPLE_PERIOD 16   // clocks per conversion

`endif

// File: hw/capture_pkg.sv
`default_nettype none

`include "capture_config.svh"

package capture_pkg;

    localparam int word_bits = 16;                       // one link word
    localparam int chan_bits = $clog2(`CAP_NUM_CHANNELS);
    localparam int seq_bits  = 8;                        // frame counter per channel

    typedef logic [`CAP_SAMPLE_BITS-1:0] sample_t;

    // header view, first word of every frame
    typedef struct packed {
        logic                                    tag;   // always 1 here
        logic [chan_bits-1:0]                    chan;
        logic [seq_bits-1:0]                     seq;
        logic [word_bits-2-chan_bits-seq_bits:0] pad;
    } frame_hdr_t;

    // sample view, the 16 words after the header
    typedef struct packed {
        logic                                tag;       // always 0 here
        logic [word_bits-2-`CAP_SAMPLE_BITS:0] pad;
        sample_t                             sample;
    } frame_smp_t;

    // same 16 bits, decoded by tag
    typedef union packed {
        frame_hdr_t hdr;
        frame_smp_t smp;
    } frame_word_u;

    typedef struct packed {
        logic        valid;
        frame_word_u word;
    } chan_link_t;

    typedef struct packed {
        logic bit_en;      // sample adc_data this cycle
        logic word_done;   // full word sitting in the shift registers
    } seq_ctrl_t;

endpackage

`default_nettype wire

// File: hw/adc_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "capture_config.svh"

module adc_sequencer (
    input  wire                     clk,
    input  wire                     reset_b,
    output logic                    cs_n,
    output capture_pkg::seq_ctrl_t  seq_ctrl
);

    localparam int cnt_bits = $clog2(`CAP_SAMPLE_PERIOD);

    // cycle of the last data bit, bits sit in cycles 1..SAMPLE_BITS
    localparam logic [cnt_bits-1:0] last_bit = cnt_bits'(`CAP_SAMPLE_BITS);

    // cs_n rises and word_done pulses right after the last bit
    localparam logic [cnt_bits-1:0] done_cyc = cnt_bits'(`CAP_SAMPLE_BITS + 1);

    localparam logic [cnt_bits-1:0] last_cyc = cnt_bits'(`CAP_SAMPLE_PERIOD - 1);

    logic [cnt_bits-1:0] period_cnt;   // position inside the conversion period
    logic                bit_window;

    // reset parks the counter in the idle tail of a period
    // so cs_n is high and both strobes are low
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            period_cnt <= last_cyc;
        end else if (period_cnt == last_cyc) begin
            period_cnt <= '0;                    // cs_n falls next cycle
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign bit_window = (period_cnt != '0) && (period_cnt <= last_bit);

    // chip select low from cycle 0 through the last bit
    assign cs_n = period_cnt > last_bit;

    assign seq_ctrl.bit_en    = bit_window;               // shared by all channels
    assign seq_ctrl.word_done = period_cnt == done_cyc;   // one clock wide

endmodule

`default_nettype wire

// File: hw/channel_capture.sv
`timescale 1ns/10ps
`default_nettype none

`include "capture_config.svh"

module channel_capture #(
    parameter int chan_id = 0                    // channel field of the header
) (
    input  wire                      clk,
    input  wire                      reset_b,
    input  wire                      adc_data,
    input  wire capture_pkg::seq_ctrl_t seq_ctrl,
    input  wire capture_pkg::sample_t   threshold,
    input  wire                      credit_return,
    output capture_pkg::chan_link_t  link
);

    import capture_pkg::*;

    localparam int depth     = `CAP_BUF_DEPTH;
    localparam int ptr_bits  = $clog2(depth);
    localparam int cred_bits = $clog2(`CAP_CHAN_CREDITS + 1);

    localparam logic [ptr_bits:0]     pre_fill  = (ptr_bits + 1)'(depth - `CAP_POST_TRIG);
    localparam logic [ptr_bits:0]     last_word = (ptr_bits + 1)'(depth);
    localparam logic [ptr_bits-1:0]   post_trig = ptr_bits'(`CAP_POST_TRIG);
    localparam logic [chan_bits-1:0]  hdr_chan  = chan_bits'(chan_id);

    typedef enum logic [1:0] {
        st_arm,     // filling, trigger allowed once pre_fill reached
        st_post,    // counting samples after the trigger
        st_send     // buffer frozen, frame going out
    } state_t;

    state_t               state;
    sample_t              shift_reg;          // serial word being assembled
    sample_t              prev_sample;        // last sample written
    sample_t              ring_buf [depth];
    logic [ptr_bits-1:0]  wr_ptr;             // oldest entry once frozen
    logic [ptr_bits:0]    fill_cnt;           // saturates at pre_fill
    logic [ptr_bits-1:0]  post_cnt;
    logic [ptr_bits:0]    rd_cnt;             // 0 header, 1..depth samples
    logic [ptr_bits-1:0]  rd_ptr;
    logic [seq_bits-1:0]  seq_num;
    logic [cred_bits-1:0] credits;
    logic                 capture_en;
    logic                 trig;
    logic                 send;
    frame_word_u          word;

    always_ff @(posedge clk) begin
        if (seq_ctrl.bit_en) begin
            shift_reg <= {shift_reg[`CAP_SAMPLE_BITS-2:0], adc_data};   // MSB first
        end
    end

    // samples arriving while frozen are dropped
    assign capture_en = seq_ctrl.word_done && (state != st_send);

    // rising crossing, only once enough history is in the buffer
    assign trig = capture_en && (state == st_arm) && (fill_cnt >= pre_fill)
                  && (prev_sample <= threshold) && (shift_reg > threshold);

    always_ff @(posedge clk) begin
        if (capture_en) begin
            ring_buf[wr_ptr] <= shift_reg;
            prev_sample      <= shift_reg;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= st_arm;
            wr_ptr   <= '0;
            fill_cnt <= '0;
            post_cnt <= '0;
            rd_cnt   <= '0;
            seq_num  <= '0;
        end else begin
            case (state)
                st_arm: begin
                    if (capture_en) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (fill_cnt < pre_fill) begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                        if (trig) begin
                            state    <= st_post;
                            post_cnt <= post_trig;
                        end
                    end
                end
                st_post: begin
                    if (capture_en) begin
                        wr_ptr   <= wr_ptr + 1'b1;
                        post_cnt <= post_cnt - 1'b1;
                        if (post_cnt == 1) begin
                            state  <= st_send;     // freeze, header next cycle
                            rd_cnt <= '0;
                        end
                    end
                end
                st_send: begin
                    if (send) begin
                        if (rd_cnt == last_word) begin
                            state    <= st_arm;    // rearm with a fresh fill count
                            fill_cnt <= '0;
                            seq_num  <= seq_num + 1'b1;
                        end else begin
                            rd_cnt <= rd_cnt + 1'b1;
                        end
                    end
                end
                default: state <= st_arm;
            endcase
        end
    end

    // one credit per word, returned when the drain pops it
    assign send = (state == st_send) && (credits != '0);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            credits <= cred_bits'(`CAP_CHAN_CREDITS);
        end else begin
            credits <= credits - cred_bits'(send) + cred_bits'(credit_return);
        end
    end

    assign rd_ptr = wr_ptr + rd_cnt[ptr_bits-1:0] - 1'b1;   // oldest first

    always_comb begin
        word = '0;
        if (rd_cnt == '0) begin
            word.hdr.tag  = 1'b1;
            word.hdr.chan = hdr_chan;
            word.hdr.seq  = seq_num;
        end else begin
            word.smp.tag    = 1'b0;
            word.smp.sample = ring_buf[rd_ptr];
        end
    end

    assign link.valid = send;
    assign link.word  = word;

endmodule

`default_nettype wire

// File: hw/frame_drain.sv
`timescale 1ns/10ps
`default_nettype none

`include "capture_config.svh"

module frame_drain (
    input  wire                          clk,
    input  wire                          reset_b,
    input  wire capture_pkg::chan_link_t chan_links [`CAP_NUM_CHANNELS],
    input  wire                          tx_credit,
    output logic [`CAP_NUM_CHANNELS-1:0] credit_return,
    output capture_pkg::chan_link_t      tx_link
);

    import capture_pkg::*;

    localparam int n_ch       = `CAP_NUM_CHANNELS;
    localparam int slot_depth = `CAP_CHAN_CREDITS;
    localparam int slot_bits  = $clog2(slot_depth);
    localparam int tx_bits    = $clog2(`CAP_TX_CREDITS + 1);
    localparam int smp_bits   = $clog2(`CAP_BUF_DEPTH);

    localparam logic [smp_bits-1:0] last_smp = smp_bits'(`CAP_BUF_DEPTH - 1);

    frame_word_u          head [n_ch];      // oldest word of each slot
    logic [n_ch-1:0]      slot_nempty;
    logic [tx_bits-1:0]   tx_cnt;           // credits toward the outside
    logic                 locked;           // inside a frame of cur_ch
    logic [chan_bits-1:0] cur_ch;           // last channel served
    logic [chan_bits-1:0] cand;
    logic [chan_bits-1:0] pick_ch;
    logic [chan_bits-1:0] sel_ch;
    logic                 pick_ok;
    logic                 sel_ok;
    logic                 pop;
    logic [smp_bits-1:0]  smp_cnt;          // samples sent in the locked frame
    logic                 tx_valid;
    frame_word_u          tx_word;

    for (genvar c = 0; c < n_ch; c++) begin : g_slot
        frame_word_u          mem [slot_depth];
        logic [slot_bits-1:0] wr_ptr;
        logic [slot_bits-1:0] rd_ptr;
        logic [slot_bits:0]   cnt;
        logic                 push;
        logic                 pull;

        assign push = chan_links[c].valid;           // channel credits prevent overflow
        assign pull = pop && (sel_ch == chan_bits'(c));

        assign credit_return[c] = pull;              // one pulse per popped word
        assign head[c]          = mem[rd_ptr];
        assign slot_nempty[c]   = cnt != '0;

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= chan_links[c].word;
            end
        end

        always_ff @(posedge clk or negedge reset_b) begin
            if (!reset_b) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                cnt    <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pull) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                if (push && !pull) begin
                    cnt <= cnt + 1'b1;
                end else if (pull && !push) begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // round robin from the channel after cur_ch, only slots holding a header
    always_comb begin
        pick_ok = 1'b0;
        pick_ch = cur_ch;
        cand    = cur_ch;
        for (int i = 1; i <= n_ch; i++) begin
            cand = cur_ch + chan_bits'(i);
            if (!pick_ok && slot_nempty[cand] && head[cand].hdr.tag) begin
                pick_ok = 1'b1;
                pick_ch = cand;
            end
        end
    end

    assign sel_ch = locked ? cur_ch : pick_ch;
    assign sel_ok = locked ? slot_nempty[cur_ch] : pick_ok;
    assign pop    = sel_ok && (tx_cnt != '0);   // credit spent at pop time

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            tx_cnt   <= tx_bits'(`CAP_TX_CREDITS);
            tx_valid <= 1'b0;
            locked   <= 1'b0;
            cur_ch   <= chan_bits'(n_ch - 1);    // first search starts at channel 0
            smp_cnt  <= '0;
        end else begin
            tx_valid <= pop;
            if (pop && !tx_credit) begin
                tx_cnt <= tx_cnt - 1'b1;
            end else if (tx_credit && !pop) begin
                tx_cnt <= tx_cnt + 1'b1;
            end
            if (pop) begin
                if (!locked) begin
                    locked  <= 1'b1;             // header popped, hold this channel
                    cur_ch  <= pick_ch;
                    smp_cnt <= '0;
                end else if (smp_cnt == last_smp) begin
                    locked <= 1'b0;              // frame complete
                end else begin
                    smp_cnt <= smp_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            tx_word <= head[sel_ch];
        end
    end

    assign tx_link.valid = tx_valid;
    assign tx_link.word  = tx_word;

endmodule

`default_nettype wire

// File: hw/capture_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "capture_config.svh"

module capture_top (
    input  wire                          clk,
    input  wire                          reset_b,
    input  wire [`CAP_NUM_CHANNELS-1:0]  adc_data,     // one serial line per ADC
    input  wire capture_pkg::sample_t    threshold,
    input  wire                          tx_credit,
    output logic                         cs_n,         // shared by all ADCs
    output capture_pkg::chan_link_t      tx_link
);

    import capture_pkg::*;

    seq_ctrl_t                    seq_ctrl;            // broadcast strobes
    chan_link_t                   chan_links [`CAP_NUM_CHANNELS];
    logic [`CAP_NUM_CHANNELS-1:0] credit_return;

    adc_sequencer u_seq (
        .clk      (clk),
        .reset_b  (reset_b),
        .cs_n     (cs_n),
        .seq_ctrl (seq_ctrl)
    );

    // one capture block per ADC, chan_id lands in its headers
    for (genvar c = 0; c < `CAP_NUM_CHANNELS; c++) begin : g_chan
        channel_capture #(
            .chan_id (c)
        ) u_chan (
            .clk           (clk),
            .reset_b       (reset_b),
            .adc_data      (adc_data[c]),
            .seq_ctrl      (seq_ctrl),
            .threshold     (threshold),
            .credit_return (credit_return[c]),
            .link          (chan_links[c])
        );
    end

    frame_drain u_drain (
        .clk           (clk),
        .reset_b       (reset_b),
        .chan_links    (chan_links),
        .tx_credit     (tx_credit),
        .credit_return (credit_return),
        .tx_link       (tx_link)
    );

endmodule

`default_nettype wire

// File: test/capture_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "capture_config.svh"

module capture_properties (
    input wire                          clk,
    input wire                          reset_b,
    input wire                          cs_n,
    input wire                          tx_credit,
    input wire capture_pkg::chan_link_t tx_link,
    input wire capture_pkg::seq_ctrl_t  seq_ctrl
);

    import capture_pkg::*;

    int   tx_held;      // credits seen from the outside
    logic seen_done;    // first conversion finished

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            tx_held   <= `CAP_TX_CREDITS;
            seen_done <= 1'b0;
        end else begin
            tx_held <= tx_held - int'(tx_link.valid) + int'(tx_credit);
            if (seq_ctrl.word_done) begin
                seen_done <= 1'b1;
            end
        end
    end

    // a valid word always has a credit behind it
    a_tx_credit: assert property (@(posedge clk) disable iff (!reset_b)
        tx_link.valid |-> tx_held > 0)
        else $error("tx word sent without a credit");

    a_done_timing: assert property (@(posedge clk) disable iff (!reset_b)
        $fell(cs_n) |-> ##11 seq_ctrl.word_done)
        else $error("word_done not 11 cycles after cs_n fall");

    // quiet bus right out of reset
    a_reset_idle: assert property (@(posedge clk)
        $rose(reset_b) |-> cs_n && !seq_ctrl.bit_en && !seq_ctrl.word_done)
        else $error("sequencer not idle after reset");

    a_no_early_tx: assert property (@(posedge clk) disable iff (!reset_b)
        !seen_done |-> !tx_link.valid)
        else $error("tx word before first conversion");

endmodule

bind capture_top capture_properties u_props (
    .clk       (clk),
    .reset_b   (reset_b),
    .cs_n      (cs_n),
    .tx_credit (tx_credit),
    .tx_link   (tx_link),
    .seq_ctrl  (seq_ctrl)
);

`default_nettype wire

// File: test/capture_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "capture_config.svh"

module capture_tb;

    import capture_pkg::*;

    localparam int n_ch       = `CAP_NUM_CHANNELS;
    localparam int n_tests    = 3;
    localparam int frames_min = 3;     // per channel per test
    // a frame takes up to about 64 conversions and the channels run in parallel
    localparam int wd_cycles  = n_tests * frames_min * 64 * `CAP_SAMPLE_PERIOD + 2000;

    logic            clk;
    logic            reset_b;
    logic [n_ch-1:0] adc_data;
    sample_t         threshold;
    logic            tx_credit;
    logic            cs_n;
    chan_link_t      tx_link;

    logic [15:0] lfsr;
    int          bit_idx;              // serial bit being driven
    int          conv_k;               // sawtooth index shared by all ADCs
    int          cycle;
    int          due_q[$];             // cycles when credits go back
    bit          long_mode;
    bit          hold;
    int          errors;
    int          checks;
    int          tx_held;
    string       cur_test;
    int          thr_cur;
    int          thr_old;
    bit          in_frame;
    int          frm_ch;
    int          frm_idx;
    int          smp [`CAP_BUF_DEPTH];
    int          exp_seq [n_ch];
    int          phase_frames [n_ch];

    capture_top DUT (
        .clk       (clk),
        .reset_b   (reset_b),
        .adc_data  (adc_data),
        .threshold (threshold),
        .tx_credit (tx_credit),
        .cs_n      (cs_n),
        .tx_link   (tx_link)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int step_of(int c);
        case (c)
            0: return 37;
            1: return 53;
            2: return 71;
            default: return 97;
        endcase
    endfunction

    function automatic logic adc_bit(int c, int k, int b);
        logic [9:0] v;
        v = 10'((k * step_of(c)) % 1024);
        return v[b];
    endfunction

    // Galois LFSR stepped once per bit
    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic report_fail(string what, int exp_v, int act_v);
        $display("Fail %s %s expected %0d actual %0d", cur_test, what, exp_v, act_v);
        errors++;
    endtask

    task automatic check_frame();
        int d;
        for (int i = 1; i < `CAP_BUF_DEPTH; i++) begin
            d = (smp[i] + 1024 - smp[i-1]) % 1024;
            checks++;
            assert (d == step_of(frm_ch)) else report_fail("sample step", step_of(frm_ch), d);
        end
        checks++;
        // only the first frame of a phase can be frozen under the old threshold
        assert ((smp[7] > thr_cur && smp[6] <= thr_cur) ||
                (phase_frames[frm_ch] == 0 && smp[7] > thr_old && smp[6] <= thr_old))
            else report_fail("trigger sample", thr_cur + 1, smp[7]);
        phase_frames[frm_ch]++;
        exp_seq[frm_ch] = (exp_seq[frm_ch] + 1) % 256;
    endtask

    // sawtooth ADCs drive a new bit on each edge while selected
    always @(posedge clk) begin
        if (!cs_n) begin
            if (bit_idx >= 0) begin
                for (int c = 0; c < n_ch; c++) begin
                    adc_data[c] <= adc_bit(c, conv_k, bit_idx);
                end
            end
            bit_idx = bit_idx - 1;
        end else begin
            if (bit_idx < 9) begin
                conv_k = conv_k + 1;
            end
            bit_idx = 9;
        end
    end

    // credit return driver
    always @(posedge clk) begin
        if (!hold && due_q.size() > 0 && due_q[0] <= cycle) begin
            tx_credit <= 1'b1;
            void'(due_q.pop_front());
        end else begin
            tx_credit <= 1'b0;
        end
    end

    // frame checker samples outputs at the falling edge
    always @(negedge clk) begin
        cycle++;
        if (reset_b && tx_link.valid) begin
            checks++;
            assert (tx_held > 0) else begin
                $display("tx word seen while no credit was held");
                errors++;
            end
            tx_held--;
            due_q.push_back(cycle + (long_mode ? take_bits(6) : take_bits(3)));
            if (!in_frame) begin
                checks++;
                assert (tx_link.word.hdr.tag) else report_fail("header tag", 1, 0);
                frm_ch   = int'(tx_link.word.hdr.chan);
                frm_idx  = 0;
                in_frame = 1'b1;
                checks++;
                assert (int'(tx_link.word.hdr.seq) == exp_seq[frm_ch])
                    else report_fail("sequence", exp_seq[frm_ch], int'(tx_link.word.hdr.seq));
            end else begin
                checks++;
                assert (!tx_link.word.smp.tag) else report_fail("sample tag", 0, 1);
                smp[frm_idx] = int'(tx_link.word.smp.sample);
                frm_idx++;
                if (frm_idx == `CAP_BUF_DEPTH) begin
                    in_frame = 1'b0;
                    check_frame();
                end
            end
        end
        if (reset_b && tx_credit) begin
            tx_held++;
        end
    end

    function automatic bit phase_done();
        for (int c = 0; c < n_ch; c++) begin
            if (phase_frames[c] < frames_min) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic run_test(string name, int thr, bit slow);
        int err0;
        err0 = errors;
        @(posedge clk);
        threshold <= sample_t'(thr);
        @(negedge clk);
        cur_test  = name;
        thr_old   = thr_cur;
        thr_cur   = thr;
        long_mode = slow;
        for (int c = 0; c < n_ch; c++) begin
            phase_frames[c] = 0;
        end
        if (slow) begin
            hold = 1'b1;               // starve the drain of credits
            repeat (200) @(negedge clk);
            hold = 1'b0;
        end
        while (!phase_done()) begin
            @(negedge clk);
        end
        $display("test %s done, frames %0d %0d %0d %0d, errors %0d", name, phase_frames[0],
                 phase_frames[1], phase_frames[2], phase_frames[3], errors - err0);
    endtask

    initial begin
        lfsr      = 16'd45834;
        reset_b   = 1'b0;
        adc_data  = '0;
        threshold = sample_t'(500);
        tx_credit = 1'b0;
        bit_idx   = 9;
        conv_k    = 0;
        cycle     = 0;
        hold      = 1'b0;
        long_mode = 1'b0;
        errors    = 0;
        checks    = 0;
        tx_held   = `CAP_TX_CREDITS;
        thr_cur   = 500;
        thr_old   = 500;
        in_frame  = 1'b0;
        cur_test  = "reset";
        for (int c = 0; c < n_ch; c++) begin
            exp_seq[c] = 0;
        end
        repeat (4) @(posedge clk);
        reset_b <= 1'b1;
        run_test("thr500", 500, 1'b0);
        run_test("thr200", 200, 1'b0);
        run_test("backpressure", 200, 1'b1);
        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout in test %s, frames did not arrive in time", cur_test);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hw/capture_pkg.sv
hw/adc_sequencer.sv
hw/channel_capture.sv
hw/frame_drain.sv
hw/capture_top.sv
test/capture_properties.sv
test/capture_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module capture_tb -f src.f -o capture_sim
./obj_dir/capture_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
grep -q "Testbench passed" sim.log
